// File: alu_pkg.sv
////////////////////////////////////////////////////////////
// vector alu package: register and datapath widths, beat
// count, adder lane layout, opcode and element-width enums
////////////////////////////////////////////////////////////

package alu_pkg;

    ////////////////////////////////////////////////////////////
    // widths

    // one vector register, processed in beats of OP_W bits
    localparam int unsigned VREG_W     = 128;
    localparam int unsigned OP_W       = 32;
    localparam int unsigned BEATS      = VREG_W / OP_W;
    localparam int unsigned BEAT_CNT_W = 2;

    // destination register address
    localparam int unsigned ADDR_W = 5;

    ////////////////////////////////////////////////////////////
    // adder lane layout

    // each byte lane carries one carry-control bit below its byte
    localparam int unsigned LANES     = OP_W / 8;
    localparam int unsigned LANE_BITS = 9;
    localparam int unsigned LANE_W    = LANES * LANE_BITS;

    ////////////////////////////////////////////////////////////
    // enums

    // operation codes
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SRA = 4'd7,
        ALU_SEQ = 4'd8,
        ALU_SLT = 4'd9
    } alu_op_e;

    // element width
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

endpackage

// File: alu_beat_if.sv
////////////////////////////////////////////////////////////
// operand beat interface between sequencer and datapath
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface alu_beat_if
    import alu_pkg::*;
();

    // beat qualifiers
    logic              valid;
    logic              last;

    // operation attributes, constant over the four beats
    alu_op_e           op;
    eew_e              eew;
    logic [ADDR_W-1:0] vd;

    // current slices of vs1 and vs2
    logic [OP_W-1:0]   opa;
    logic [OP_W-1:0]   opb;

    modport src (
        output valid, last, op, eew, vd, opa, opb
    );

    modport dst (
        input  valid, last, op, eew, vd, opa, opb
    );

endinterface

// File: alu_seq.sv
////////////////////////////////////////////////////////////
// alu sequencer with operation acceptance, beat counter and
// operand shift registers feeding the beat interface
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_seq
    import alu_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              op_valid_i,
    input  alu_op_e           op_i,
    input  eew_e              eew_i,
    input  logic [VREG_W-1:0] vs1_i,
    input  logic [VREG_W-1:0] vs2_i,
    input  logic [ADDR_W-1:0] vd_i,
    output logic              op_ack_o,
    alu_beat_if.src           beat
);

    logic                  busy_q;
    logic [BEAT_CNT_W-1:0] cnt_q;
    logic                  last;

    logic [VREG_W-1:0]     vs1_q;
    logic [VREG_W-1:0]     vs2_q;
    alu_op_e               op_q;
    eew_e                  eew_q;
    logic [ADDR_W-1:0]     vd_q;

    assign last = busy_q && (cnt_q == BEAT_CNT_W'(BEATS - 1));

    // a new op may start while the final beat of the previous one is shown
    assign op_ack_o = op_valid_i && (!busy_q || last);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (op_ack_o) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (busy_q) begin
            busy_q <= !last;
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    // operands shift down by one beat per cycle and the lowest slice is shown
    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            vs1_q <= vs1_i;
            vs2_q <= vs2_i;
            op_q  <= op_i;
            eew_q <= eew_i;
            vd_q  <= vd_i;
        end else begin
            vs1_q <= {{OP_W{1'b0}}, vs1_q[VREG_W-1:OP_W]};
            vs2_q <= {{OP_W{1'b0}}, vs2_q[VREG_W-1:OP_W]};
        end
    end

    assign beat.valid = busy_q;
    assign beat.last  = last;
    assign beat.op    = op_q;
    assign beat.eew   = eew_q;
    assign beat.vd    = vd_q;
    assign beat.opa   = vs1_q[OP_W-1:0];
    assign beat.opb   = vs2_q[OP_W-1:0];

    ////////////////////////////////////////////////////////////
    // assertions

    // the last beat is shown one register length after acceptance
    last_after_beats_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) last |-> $past(op_ack_o, BEATS)
    );

    // a beat train only ends right after its last beat
    valid_ends_on_last_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $fell(busy_q) |-> $past(last)
    );

endmodule

// File: alu_adder.sv
////////////////////////////////////////////////////////////
// fracturable lane adder with per-element compare flags
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_adder
    import alu_pkg::*;
(
    alu_beat_if.dst          beat,
    output logic [OP_W-1:0]  sum_o,
    output logic [LANES-1:0] neq_o,
    output logic [LANES-1:0] lt_o
);

    logic              sub;
    logic [OP_W-1:0]   opa_x;
    logic [LANES-1:0]  brk;
    logic [LANE_W-1:0] pad_a;
    logic [LANE_W-1:0] pad_b;
    logic [LANE_W-1:0] pad_sum;
    logic [LANES-1:0]  sa, sb, sr;
    logic [LANES-1:0]  ovf, lt_b, nz_b;

    // compares are computed as vs2 - vs1
    assign sub   = (beat.op == ALU_SUB) || (beat.op == ALU_SEQ) || (beat.op == ALU_SLT);
    assign opa_x = sub ? ~beat.opa : beat.opa;

    // lanes that start a new element
    always_comb begin
        brk[0] = 1'b1;
        brk[1] = (beat.eew == EEW_8);
        brk[2] = (beat.eew != EEW_32);
        brk[3] = (beat.eew == EEW_8);
    end

    // at an element start both control bits equal sub, which stops the
    // incoming carry and injects the subtract carry; elsewhere 1+0 passes it
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            pad_a[LANE_BITS*i +: LANE_BITS] = {opa_x[8*i +: 8], brk[i] ? sub : 1'b1};
            pad_b[LANE_BITS*i +: LANE_BITS] = {beat.opb[8*i +: 8], brk[i] & sub};
        end
    end

    assign pad_sum = pad_a + pad_b;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            sum_o[8*i +: 8] = pad_sum[LANE_BITS*i+1 +: 8];
            sa[i]           = opa_x[8*i+7];
            sb[i]           = beat.opb[8*i+7];
            sr[i]           = pad_sum[LANE_BITS*i+8];
            nz_b[i]         = |pad_sum[LANE_BITS*i+1 +: 8];
        end
    end

    // signed overflow follows the addition rule since opa is pre-inverted
    assign ovf  = ~(sa ^ sb) & (sa ^ sr);
    assign lt_b = ovf ^ sr;

    // flags are valid at the top lane of an element, spread them over it
    always_comb begin
        case (beat.eew)
            EEW_8: begin
                lt_o  = lt_b;
                neq_o = nz_b;
            end
            EEW_16: begin
                lt_o  = {{2{lt_b[3]}}, {2{lt_b[1]}}};
                neq_o = {{2{nz_b[3] | nz_b[2]}}, {2{nz_b[1] | nz_b[0]}}};
            end
            default: begin
                lt_o  = {LANES{lt_b[3]}};
                neq_o = {LANES{|nz_b}};
            end
        endcase
    end

endmodule

// File: alu_shifter.sv
////////////////////////////////////////////////////////////
// per-element barrel shifter: sll, srl and sra
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_shifter
    import alu_pkg::*;
(
    alu_beat_if.dst         beat,
    output logic [OP_W-1:0] shift_o
);

    logic [OP_W-1:0] res8;
    logic [OP_W-1:0] res16;
    logic [OP_W-1:0] res32;

    // shift amount is the low bits of the matching vs1 element
    always_comb begin
        for (int i = 0; i < OP_W / 8; i++) begin
            if (beat.op == ALU_SRA) begin
                res8[8*i +: 8] = $signed(beat.opb[8*i +: 8]) >>> beat.opa[8*i +: 3];
            end else if (beat.op == ALU_SRL) begin
                res8[8*i +: 8] = beat.opb[8*i +: 8] >> beat.opa[8*i +: 3];
            end else begin
                res8[8*i +: 8] = beat.opb[8*i +: 8] << beat.opa[8*i +: 3];
            end
        end
        for (int i = 0; i < OP_W / 16; i++) begin
            if (beat.op == ALU_SRA) begin
                res16[16*i +: 16] = $signed(beat.opb[16*i +: 16]) >>> beat.opa[16*i +: 4];
            end else if (beat.op == ALU_SRL) begin
                res16[16*i +: 16] = beat.opb[16*i +: 16] >> beat.opa[16*i +: 4];
            end else begin
                res16[16*i +: 16] = beat.opb[16*i +: 16] << beat.opa[16*i +: 4];
            end
        end
        if (beat.op == ALU_SRA) begin
            res32 = $signed(beat.opb) >>> beat.opa[4:0];
        end else if (beat.op == ALU_SRL) begin
            res32 = beat.opb >> beat.opa[4:0];
        end else begin
            res32 = beat.opb << beat.opa[4:0];
        end
    end

    always_comb begin
        case (beat.eew)
            EEW_8:   shift_o = res8;
            EEW_16:  shift_o = res16;
            default: shift_o = res32;
        endcase
    end

endmodule

// File: alu_result.sv
////////////////////////////////////////////////////////////
// execute register, element result select, result shift
// register and register write pulse
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_result
    import alu_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic [OP_W-1:0]   sum_i,
    input  logic [OP_W-1:0]   shift_i,
    input  logic [LANES-1:0]  neq_i,
    input  logic [LANES-1:0]  lt_i,
    alu_beat_if.dst           beat,
    output logic              wr_en_o,
    output logic [ADDR_W-1:0] wr_addr_o,
    output logic [VREG_W-1:0] wr_data_o
);

    // execute stage
    logic              ex_valid_q;
    logic              ex_last_q;
    alu_op_e           ex_op_q;
    eew_e              ex_eew_q;
    logic [ADDR_W-1:0] ex_vd_q;
    logic [OP_W-1:0]   ex_sum_q, ex_shift_q, ex_opa_q, ex_opb_q;
    logic [LANES-1:0]  ex_neq_q, ex_lt_q;

    logic [LANES-1:0]  flag;
    logic [OP_W-1:0]   cmp_res;
    logic [OP_W-1:0]   elem_res;

    logic              wr_en_q;
    logic [ADDR_W-1:0] wr_addr_q;
    logic [VREG_W-1:0] res_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex_valid_q <= 1'b0;
            ex_last_q  <= 1'b0;
            wr_en_q    <= 1'b0;
        end else begin
            ex_valid_q <= beat.valid;
            ex_last_q  <= beat.valid && beat.last;
            wr_en_q    <= ex_valid_q && ex_last_q;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_op_q    <= beat.op;
        ex_eew_q   <= beat.eew;
        ex_vd_q    <= beat.vd;
        ex_sum_q   <= sum_i;
        ex_shift_q <= shift_i;
        ex_opa_q   <= beat.opa;
        ex_opb_q   <= beat.opb;
        ex_neq_q   <= neq_i;
        ex_lt_q    <= lt_i;
    end

    ////////////////////////////////////////////////////////////
    // result select

    assign flag = (ex_op_q == ALU_SEQ) ? ~ex_neq_q : ex_lt_q;

    // compare result is 1 or 0 in the low bit of each element
    always_comb begin
        cmp_res = '0;
        case (ex_eew_q)
            EEW_8: begin
                for (int i = 0; i < LANES; i++) begin
                    cmp_res[8*i] = flag[i];
                end
            end
            EEW_16: begin
                for (int i = 0; i < LANES / 2; i++) begin
                    cmp_res[16*i] = flag[2*i];
                end
            end
            default: cmp_res[0] = flag[0];
        endcase
    end

    always_comb begin
        case (ex_op_q)
            ALU_AND:                   elem_res = ex_opa_q & ex_opb_q;
            ALU_OR:                    elem_res = ex_opa_q | ex_opb_q;
            ALU_XOR:                   elem_res = ex_opa_q ^ ex_opb_q;
            ALU_SLL, ALU_SRL, ALU_SRA: elem_res = ex_shift_q;
            ALU_SEQ, ALU_SLT:          elem_res = cmp_res;
            default:                   elem_res = ex_sum_q;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // result shift register and write

    // beats enter at the top, so beat 0 ends up in the low slice
    always_ff @(posedge clk_i) begin
        if (ex_valid_q) begin
            res_q <= {elem_res, res_q[VREG_W-1:OP_W]};
        end
        if (ex_valid_q && ex_last_q) begin
            wr_addr_q <= ex_vd_q;
        end
    end

    assign wr_en_o   = wr_en_q;
    assign wr_addr_o = wr_addr_q;
    assign wr_data_o = res_q;

    // ops are at least four beats apart, so writes never touch
    single_write_pulse_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni) wr_en_q |=> !wr_en_q
    );

endmodule

// File: alu_top.sv
////////////////////////////////////////////////////////////
// vector alu top level: sequencer, adder, shifter, result
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_top
    import alu_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              op_valid_i,
    input  alu_op_e           op_i,
    input  eew_e              eew_i,
    input  logic [VREG_W-1:0] vs1_i,
    input  logic [VREG_W-1:0] vs2_i,
    input  logic [ADDR_W-1:0] vd_i,
    output logic              op_ack_o,
    output logic              wr_en_o,
    output logic [ADDR_W-1:0] wr_addr_o,
    output logic [VREG_W-1:0] wr_data_o
);

    logic [OP_W-1:0]  sum;
    logic [OP_W-1:0]  shift;
    logic [LANES-1:0] neq;
    logic [LANES-1:0] lt;

    alu_beat_if beat_if ();

    alu_seq alu_seq_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .op_valid_i (op_valid_i),
        .op_i       (op_i),
        .eew_i      (eew_i),
        .vs1_i      (vs1_i),
        .vs2_i      (vs2_i),
        .vd_i       (vd_i),
        .op_ack_o   (op_ack_o),
        .beat       (beat_if.src)
    );

    alu_adder alu_adder_inst (
        .beat  (beat_if.dst),
        .sum_o (sum),
        .neq_o (neq),
        .lt_o  (lt)
    );

    alu_shifter alu_shifter_inst (
        .beat    (beat_if.dst),
        .shift_o (shift)
    );

    alu_result alu_result_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .sum_i     (sum),
        .shift_i   (shift),
        .neq_i     (neq),
        .lt_i      (lt),
        .beat      (beat_if.dst),
        .wr_en_o   (wr_en_o),
        .wr_addr_o (wr_addr_o),
        .wr_data_o (wr_data_o)
    );

endmodule

// File: tb_alu.sv
////////////////////////////////////////////////////////////
// vector alu testbench that replays the golden file and checks
// write address, write data, write pulse timing and acks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_alu
    import alu_pkg::*;
();

    // fields per golden line are op, eew, vs1, vs2, vd, gap and expected
    localparam int N_OPS    = 18;
    localparam int N_FIELDS = 7;

    logic              clk_i;
    logic              rst_ni;
    logic              op_valid_i;
    alu_op_e           op_i;
    eew_e              eew_i;
    logic [VREG_W-1:0] vs1_i;
    logic [VREG_W-1:0] vs2_i;
    logic [ADDR_W-1:0] vd_i;
    logic              op_ack_o;
    logic              wr_en_o;
    logic [ADDR_W-1:0] wr_addr_o;
    logic [VREG_W-1:0] wr_data_o;

    logic [VREG_W-1:0] golden [0:N_OPS*N_FIELDS-1];

    // one entry per accepted op in issue order
    logic [ADDR_W-1:0] exp_addr_q [$];
    logic [VREG_W-1:0] exp_data_q [$];
    int                exp_cycle_q [$];

    logic [ADDR_W-1:0] exp_addr;
    logic [VREG_W-1:0] exp_data;
    int                exp_cycle;

    int cycle;
    int limit;
    int errors;
    int accept_cycle;

    alu_top alu_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // drive one golden line and hold it until the sequencer takes it
    task automatic issue_op(input int n);
        int base;
        int gap;
        base = n * N_FIELDS;
        gap  = int'(golden[base+5][15:0]);
        if (gap > 0) begin
            op_valid_i <= 1'b0;
            repeat (gap) @(posedge clk_i);
        end
        op_valid_i <= 1'b1;
        op_i       <= alu_op_e'(golden[base][3:0]);
        eew_i      <= eew_e'(golden[base+1][1:0]);
        vs1_i      <= golden[base+2];
        vs2_i      <= golden[base+3];
        vd_i       <= golden[base+4][ADDR_W-1:0];
        do begin
            @(negedge clk_i);
        end while (!op_ack_o);
        // back-to-back ops are taken one register length apart
        if (n > 0 && gap == 0 && cycle + 1 - accept_cycle != BEATS) begin
            $display("ERROR at %0t: op %0d taken %0d cycles after the last, expected %0d",
                     $time, n, cycle + 1 - accept_cycle, BEATS);
            errors++;
        end
        accept_cycle = cycle + 1;
        // acceptance is the next rising edge and the write follows five edges later
        exp_addr_q.push_back(golden[base+4][ADDR_W-1:0]);
        exp_data_q.push_back(golden[base+6]);
        exp_cycle_q.push_back(cycle + 6);
        @(posedge clk_i);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        rst_ni     <= 1'b0;
        op_valid_i <= 1'b0;
        op_i       <= ALU_ADD;
        eew_i      <= EEW_8;
        vs1_i      <= '0;
        vs2_i      <= '0;
        vd_i       <= '0;
        $readmemh("alu_golden.txt", golden);
        limit = 20;
        for (int n = 0; n < N_OPS; n++) begin
            limit += int'(golden[n*N_FIELDS+5][15:0]) + BEATS;
        end
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int n = 0; n < N_OPS; n++) begin
            issue_op(n);
        end
        op_valid_i <= 1'b0;
        while (exp_addr_q.size() != 0) begin
            @(negedge clk_i);
        end
        // idle tail to catch a stray write
        repeat (4) @(negedge clk_i);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // write port checks and timeout

    always @(negedge clk_i) begin
        if (wr_en_o) begin
            if (exp_addr_q.size() == 0) begin
                $display("ERROR at %0t: write pulse with no operation outstanding", $time);
                errors++;
            end else begin
                exp_addr  = exp_addr_q.pop_front();
                exp_data  = exp_data_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                if (cycle != exp_cycle) begin
                    $display("ERROR at %0t: write pulse in cycle %0d, expected in cycle %0d",
                             $time, cycle, exp_cycle);
                    errors++;
                end
                if (wr_addr_o !== exp_addr) begin
                    $display("MISMATCH at %0t: wr_addr_o expected %0d got %0d",
                             $time, exp_addr, wr_addr_o);
                    errors++;
                end
                if (wr_data_o !== exp_data) begin
                    $display("MISMATCH at %0t: wr_data_o expected %h got %h",
                             $time, exp_data, wr_data_o);
                    errors++;
                end
            end
        end
        if (cycle > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("errors: %0d", errors);
            $display("sim failed");
            $finish;
        end
    end

endmodule

// File: alu_golden.txt
// op eew vs1 vs2 vd gap expected, all hex; op and eew use the enum codes
// op: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 sra 8 seq 9 slt, eew: 0 e8 1 e16 2 e32
0 0 01010101010101010101010101010101 ffffffff00ffffff0000ffff000000ff 01 2 00000000010000000101000001010100
0 1 00010001000100010001000100010001 ffffffff00ffffff0000ffff000000ff 02 0 00000000010000000001000000010100
0 2 00000001000000010000000100000001 ffffffff00ffffff0000ffff000000ff 03 0 00000000010000000001000000000100
1 0 01010101010101010101010101010101 00010000000001000000000110000000 04 3 ff00ffffffff00ffffffff000fffffff
1 1 00010001000100010001000100010001 00010000000001000000000110000000 05 0 0000ffffffff00ffffff00000fffffff
1 2 00000001000000010000000100000001 00010000000001000000000110000000 06 0 0000ffff000000ff000000000fffffff
2 0 f0f0f0f00ff00ff012345678ffff0000 ff00ff00f0f0f0f087654321aaaa5555 07 5 f000f00000f000f002244220aaaa0000
3 1 f0f0f0f00ff00ff012345678ffff0000 ff00ff00f0f0f0f087654321aaaa5555 08 0 fff0fff0fff0fff097755779ffff5555
4 2 f0f0f0f00ff00ff012345678ffff0000 ff00ff00f0f0f0f087654321aaaa5555 09 0 0ff00ff0ff00ff009551155955555555
5 0 0f0e0d0c0b0a09080706050403020100 81818181818181818181818181818181 0a 0 80402010080402818040201008040281
6 1 0003000800110010000f000400010000 80018001800180018001800180018001 0b 1 10000080400080010001080040008001
7 2 000000040000001f0000002100000008 80000000f00000007fffffff12345678 0c 0 f8000000ffffffff3fffffff00123456
7 0 0f0e0d0c0b0a09080706050403020100 81818181818181818181818181818181 0d 0 fffefcf8f0e0c081fffefcf8f0e0c081
8 0 00112233445566778899aabbccddeeff 00112233000000008899aabb00000000 0e 0 01010101000000000101010100000000
8 1 123412340000ffff567856000078abcd 123412350000ffff567856785678abcd 0f 2 00010000000100010001000000000001
9 0 0180807f00ff05050180807f00ff0505 80017f80ff00050480017f80ff000504 10 0 01000001010000010100000101000001
9 1 7fff8000ffff800000ff0100ff001235 80000001fffe7fff010000ffff001234 11 0 00010000000100000000000100000001
9 2 0000000180000000000000007ffffffe 8000000000000001ffffffff7fffffff 12 0 00000001000000000000000100000000

// File: all.f
alu_pkg.sv
alu_beat_if.sv
alu_seq.sv
alu_adder.sv
alu_shifter.sv
alu_result.sv
alu_top.sv
tb_alu.sv

// File: run.sh
#!/bin/sh
# build and run the vector alu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_alu -o tb_alu_sim

./obj_dir/tb_alu_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
